// ==== hw/event_pkg.sv ====
package event_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int NUM_LINKS = 4;

    typedef logic [31:0]          link_data_t;
    typedef logic [63:0]          hdr_data_t;
    // a set bit keeps that link out of start detection
    typedef logic [NUM_LINKS-1:0] link_mask_t;
    typedef logic [31:0]          count_t;
    typedef logic [3:0]           reg_addr_t;
    typedef logic [31:0]          reg_data_t;

    ////////////////////////////////////////////////////////////////////////////
    // bundles
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        reg_addr_t  addr;
        logic       we;
        logic [3:0] be;
        reg_data_t  wdata;
    } reg_req_t;

    typedef struct packed {
        link_data_t data;
        logic       last;
    } link_beat_t;

    typedef struct packed {
        hdr_data_t data;
        logic      last;
    } hdr_beat_t;

    typedef enum logic [1:0] {
        HDR_IDLE,
        HDR_WORD0,
        HDR_WORD1
    } hdr_state_t;

    ////////////////////////////////////////////////////////////////////////////
    // constants
    ////////////////////////////////////////////////////////////////////////////

    // marker in the top bits of header beat 0
    localparam logic [15:0] HDR_MAGIC = 16'hA55A;

    // register word indices
    localparam reg_addr_t REG_GLOBAL     = 4'd0;
    localparam reg_addr_t REG_DWORD_BASE = 4'd4;
    localparam reg_addr_t REG_OUT_BEATS  = 4'd8;
    localparam reg_addr_t REG_OUT_EVENTS = 4'd9;

endpackage

// ==== hw/event_regs.sv ====
module event_regs (
    input  logic                      aclk,
    input  logic                      rst_n_i,
    input  event_pkg::reg_req_t       reg_req_i,
    input  logic                      reg_req_valid_i,
    output logic                      reg_ack_o,
    output event_pkg::reg_data_t      reg_rdata_o,
    input  event_pkg::count_t         link_count_i [event_pkg::NUM_LINKS],
    input  event_pkg::count_t         out_beats_i,
    input  event_pkg::count_t         out_events_i,
    output logic                      event_reset_o,
    output event_pkg::link_mask_t     link_mask_o
);

    import event_pkg::*;

    reg_data_t global_word;
    reg_data_t rd_mux;
    logic      req_new;

    // first cycle of a request, before the ack goes out
    assign req_new = reg_req_valid_i && !reg_ack_o;

    assign global_word = {20'h00000, link_mask_o, 7'b0000000, event_reset_o};

    ////////////////////////////////////////////////////////////////////////////
    // read decode
    ////////////////////////////////////////////////////////////////////////////

    // bit 3 shadows the low half except at the two output counters
    always_comb begin
        case (reg_req_i.addr[3:2])
            REG_GLOBAL[3:2]: begin
                rd_mux = global_word;
            end
            REG_DWORD_BASE[3:2]: begin
                rd_mux = link_count_i[reg_req_i.addr[1:0]];
            end
            REG_OUT_BEATS[3:2]: begin
                if (reg_req_i.addr == REG_OUT_BEATS) begin
                    rd_mux = out_beats_i;
                end else if (reg_req_i.addr == REG_OUT_EVENTS) begin
                    rd_mux = out_events_i;
                end else begin
                    rd_mux = global_word;
                end
            end
            default: begin
                rd_mux = link_count_i[reg_req_i.addr[1:0]];
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // four-phase handshake and control word
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            reg_ack_o     <= 1'b0;
            event_reset_o <= 1'b0;
            link_mask_o   <= '0;
        end else begin
            if (req_new) begin
                reg_ack_o <= 1'b1;
                // every index writes the global fields
                if (reg_req_i.we && reg_req_i.be[0]) begin
                    event_reset_o <= reg_req_i.wdata[0];
                end
                if (reg_req_i.we && reg_req_i.be[1]) begin
                    link_mask_o <= reg_req_i.wdata[8 +: NUM_LINKS];
                end
            end else if (!reg_req_valid_i) begin
                reg_ack_o <= 1'b0;
            end
        end
    end

    // read data is held until the next read
    always_ff @(posedge aclk) begin
        if (req_new && !reg_req_i.we) begin
            reg_rdata_o <= rd_mux;
        end
    end

endmodule

// ==== hw/event_stat_counter.sv ====
module event_stat_counter #(
    parameter int NUM_COUNTS = 4
) (
    input  logic                  aclk,
    input  logic                  clr_i,
    input  logic [NUM_COUNTS-1:0] strobe_i,
    output event_pkg::count_t     count_o [NUM_COUNTS]
);

    // one wrapping counter per strobe, all cleared together
    always_ff @(posedge aclk) begin
        for (int i = 0; i < NUM_COUNTS; i++) begin
            if (clr_i) begin
                count_o[i] <= '0;
            end else if (strobe_i[i]) begin
                count_o[i] <= count_o[i] + 1'b1;
            end
        end
    end

endmodule

// ==== hw/link_gate.sv ====
module link_gate (
    input  logic                                aclk,
    input  logic                                rst_n_i,
    input  logic                                event_open_i,
    input  event_pkg::link_beat_t               s_link_beat_i [event_pkg::NUM_LINKS],
    input  logic [event_pkg::NUM_LINKS-1:0]     s_link_valid_i,
    output logic [event_pkg::NUM_LINKS-1:0]     s_link_ready_o,
    output event_pkg::link_beat_t               m_link_beat_o [event_pkg::NUM_LINKS],
    output logic [event_pkg::NUM_LINKS-1:0]     m_link_valid_o,
    input  logic [event_pkg::NUM_LINKS-1:0]     m_link_ready_i,
    output logic [event_pkg::NUM_LINKS-1:0]     beat_stb_o,
    output logic [event_pkg::NUM_LINKS-1:0]     last_stb_o
);

    import event_pkg::*;

    logic [1:0] open_sync;
    logic       open;

    // event-open arrives from another domain
    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            open_sync <= 2'b00;
        end else begin
            open_sync <= {open_sync[0], event_open_i};
        end
    end

    assign open = open_sync[1];

    ////////////////////////////////////////////////////////////////////////////
    // gating
    ////////////////////////////////////////////////////////////////////////////

    // while closed the source sees ready and its beats are thrown away
    assign m_link_beat_o  = s_link_beat_i;
    assign m_link_valid_o = s_link_valid_i & {NUM_LINKS{open}};
    assign s_link_ready_o = m_link_ready_i | {NUM_LINKS{!open}};

    assign beat_stb_o = m_link_valid_o & m_link_ready_i;

    always_comb begin
        for (int i = 0; i < NUM_LINKS; i++) begin
            last_stb_o[i] = beat_stb_o[i] && m_link_beat_o[i].last;
        end
    end

endmodule

// ==== hw/event_start_detect.sv ====
module event_start_detect (
    input  logic                            aclk,
    input  logic                            rst_n_i,
    input  logic [event_pkg::NUM_LINKS-1:0] last_stb_i,
    input  event_pkg::link_mask_t           link_mask_i,
    output logic                            start_o
);

    import event_pkg::*;

    logic [NUM_LINKS-1:0] last_q;
    logic                 start_d;

    // only the lowest unmasked link counts, the rest are ignored
    always_comb begin
        start_d = 1'b0;
        for (int i = NUM_LINKS - 1; i >= 0; i--) begin
            if (!link_mask_i[i]) begin
                start_d = last_q[i];
            end
        end
    end

    // two register stages, tlast to start pulse
    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            last_q  <= '0;
            start_o <= 1'b0;
        end else begin
            last_q  <= last_stb_i;
            start_o <= start_d;
        end
    end

endmodule

// ==== hw/turf_header_gen.sv ====
module turf_header_gen #(
    parameter int MAX_PENDING = 7
) (
    input  logic                  aclk,
    input  logic                  rst_n_i,
    input  logic                  start_i,
    input  event_pkg::link_mask_t link_mask_i,
    output event_pkg::hdr_beat_t  m_ev_beat_o,
    output logic                  m_ev_valid_o,
    input  logic                  m_ev_ready_i
);

    import event_pkg::*;

    localparam int PEND_W = $clog2(MAX_PENDING + 1);

    hdr_state_t        state;
    logic [PEND_W-1:0] pend_cnt;
    count_t            ev_num;
    link_mask_t        mask_q;
    logic              want;
    logic              load;

    // a request is either arriving now or already queued
    assign want = start_i || (pend_cnt != '0);

    // beat 0 loads from idle, or straight after beat 1 goes out
    assign load = want && ((state == HDR_IDLE) ||
                           ((state == HDR_WORD1) && m_ev_ready_i));

    assign m_ev_valid_o = (state != HDR_IDLE);

    ////////////////////////////////////////////////////////////////////////////
    // pending starts and event number
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            pend_cnt <= '0;
            ev_num   <= '0;
        end else begin
            case ({start_i, load})
                2'b10: begin
                    // full queue drops the start
                    if (pend_cnt != PEND_W'(MAX_PENDING)) begin
                        pend_cnt <= pend_cnt + 1'b1;
                    end
                end
                2'b01: begin
                    pend_cnt <= pend_cnt - 1'b1;
                end
                default: begin
                end
            endcase
            if (load) begin
                ev_num <= ev_num + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // output FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            state <= HDR_IDLE;
        end else begin
            case (state)
                HDR_IDLE: begin
                    if (load) begin
                        state <= HDR_WORD0;
                    end
                end
                HDR_WORD0: begin
                    if (m_ev_ready_i) begin
                        state <= HDR_WORD1;
                    end
                end
                HDR_WORD1: begin
                    if (load) begin
                        state <= HDR_WORD0;
                    end else if (m_ev_ready_i) begin
                        state <= HDR_IDLE;
                    end
                end
                default: begin
                    state <= HDR_IDLE;
                end
            endcase
        end
    end

    // beat register holds under back-pressure
    always_ff @(posedge aclk) begin
        if (load) begin
            m_ev_beat_o.data <= {HDR_MAGIC, 16'h0000, ev_num};
            m_ev_beat_o.last <= 1'b0;
            mask_q           <= link_mask_i;
        end else if ((state == HDR_WORD0) && m_ev_ready_i) begin
            m_ev_beat_o.data <= {{($bits(hdr_data_t) - NUM_LINKS){1'b0}}, mask_q};
            m_ev_beat_o.last <= 1'b1;
        end
    end

endmodule

// ==== hw/event_top.sv ====
module event_top #(
    parameter int MAX_PENDING = 7
) (
    input  logic                            aclk,
    input  logic                            rst_n_i,
    // register port
    input  event_pkg::reg_req_t             reg_req_i,
    input  logic                            reg_req_valid_i,
    output logic                            reg_ack_o,
    output event_pkg::reg_data_t            reg_rdata_o,
    // incoming links
    input  logic                            event_open_i,
    input  event_pkg::link_beat_t           s_link_beat_i [event_pkg::NUM_LINKS],
    input  logic [event_pkg::NUM_LINKS-1:0] s_link_valid_i,
    output logic [event_pkg::NUM_LINKS-1:0] s_link_ready_o,
    // gated links
    output event_pkg::link_beat_t           m_link_beat_o [event_pkg::NUM_LINKS],
    output logic [event_pkg::NUM_LINKS-1:0] m_link_valid_o,
    input  logic [event_pkg::NUM_LINKS-1:0] m_link_ready_i,
    // header stream
    output event_pkg::hdr_beat_t            m_ev_beat_o,
    output logic                            m_ev_valid_o,
    input  logic                            m_ev_ready_i
);

    import event_pkg::*;

    logic                 event_reset;
    link_mask_t           link_mask;
    logic                 core_rst_n;
    logic [NUM_LINKS-1:0] beat_stb;
    logic [NUM_LINKS-1:0] last_stb;
    logic                 start;
    logic [1:0]           out_stb;
    count_t               link_count [NUM_LINKS];
    count_t               out_count [2];

    // soft reset holds everything but the register block
    assign core_rst_n = rst_n_i && !event_reset;

    // bit 0 beats, bit 1 events
    assign out_stb[0] = m_ev_valid_o && m_ev_ready_i;
    assign out_stb[1] = m_ev_valid_o && m_ev_ready_i && m_ev_beat_o.last;

    ////////////////////////////////////////////////////////////////////////////
    // control and statistics
    ////////////////////////////////////////////////////////////////////////////

    event_regs u_regs (
        .aclk            (aclk),
        .rst_n_i         (rst_n_i),
        .reg_req_i       (reg_req_i),
        .reg_req_valid_i (reg_req_valid_i),
        .reg_ack_o       (reg_ack_o),
        .reg_rdata_o     (reg_rdata_o),
        .link_count_i    (link_count),
        .out_beats_i     (out_count[0]),
        .out_events_i    (out_count[1]),
        .event_reset_o   (event_reset),
        .link_mask_o     (link_mask)
    );

    event_stat_counter #(
        .NUM_COUNTS (NUM_LINKS)
    ) u_link_stats (
        .aclk     (aclk),
        .clr_i    (!core_rst_n),
        .strobe_i (beat_stb),
        .count_o  (link_count)
    );

    event_stat_counter #(
        .NUM_COUNTS (2)
    ) u_out_stats (
        .aclk     (aclk),
        .clr_i    (!core_rst_n),
        .strobe_i (out_stb),
        .count_o  (out_count)
    );

    ////////////////////////////////////////////////////////////////////////////
    // event path
    ////////////////////////////////////////////////////////////////////////////

    link_gate u_gate (
        .aclk           (aclk),
        .rst_n_i        (core_rst_n),
        .event_open_i   (event_open_i),
        .s_link_beat_i  (s_link_beat_i),
        .s_link_valid_i (s_link_valid_i),
        .s_link_ready_o (s_link_ready_o),
        .m_link_beat_o  (m_link_beat_o),
        .m_link_valid_o (m_link_valid_o),
        .m_link_ready_i (m_link_ready_i),
        .beat_stb_o     (beat_stb),
        .last_stb_o     (last_stb)
    );

    event_start_detect u_start (
        .aclk        (aclk),
        .rst_n_i     (core_rst_n),
        .last_stb_i  (last_stb),
        .link_mask_i (link_mask),
        .start_o     (start)
    );

    turf_header_gen #(
        .MAX_PENDING (MAX_PENDING)
    ) u_hdr (
        .aclk         (aclk),
        .rst_n_i      (core_rst_n),
        .start_i      (start),
        .link_mask_i  (link_mask),
        .m_ev_beat_o  (m_ev_beat_o),
        .m_ev_valid_o (m_ev_valid_o),
        .m_ev_ready_i (m_ev_ready_i)
    );

endmodule

// ==== tests/tb_clock.sv ====
module tb_clock #(
    parameter int PERIOD = 8
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD / 2);
            clk_o = ~clk_o;
        end
    end

endmodule

// ==== tests/tb_event_top.sv ====
module tb_event_top;

    import event_pkg::*;

    typedef enum {OP_WR, OP_RD, OP_PKT, OP_DRAIN, OP_OPEN} op_t;

    // arg is link, address, open level or random-ready flag
    // len is beats or byte enable, exp is the header count of a drain
    typedef struct {
        op_t         op;
        int          arg;
        int          len;
        logic [31:0] data;
        int          exp;
    } row_t;

    logic                 aclk;
    logic                 rst_n;
    reg_req_t             req;
    logic                 req_valid;
    logic                 ack;
    reg_data_t            rdata;
    logic                 event_open;
    link_beat_t           s_beat [NUM_LINKS];
    logic [NUM_LINKS-1:0] s_valid;
    logic [NUM_LINKS-1:0] s_ready;
    link_beat_t           m_beat [NUM_LINKS];
    logic [NUM_LINKS-1:0] m_valid;
    logic [NUM_LINKS-1:0] m_ready;
    hdr_beat_t            ev_beat;
    logic                 ev_valid;
    logic                 ev_ready;

    row_t      rows [$];
    hdr_beat_t hdr_q [$];
    integer    seed;
    int        errors;
    int        checks;
    int        cycles;
    int        limit;

    // reference model state
    logic       mdl_reset;
    link_mask_t mdl_mask;
    logic       mdl_open;
    count_t     mdl_link_cnt [NUM_LINKS];
    count_t     mdl_out_beats;
    count_t     mdl_hdr_rx;
    count_t     mdl_ev_num;

    tb_clock #(.PERIOD(8)) u_clock (.clk_o(aclk));

    event_top #(
        .MAX_PENDING (7)
    ) i_event_top (
        .aclk            (aclk),
        .rst_n_i         (rst_n),
        .reg_req_i       (req),
        .reg_req_valid_i (req_valid),
        .reg_ack_o       (ack),
        .reg_rdata_o     (rdata),
        .event_open_i    (event_open),
        .s_link_beat_i   (s_beat),
        .s_link_valid_i  (s_valid),
        .s_link_ready_o  (s_ready),
        .m_link_beat_o   (m_beat),
        .m_link_valid_o  (m_valid),
        .m_link_ready_i  (m_ready),
        .m_ev_beat_o     (ev_beat),
        .m_ev_valid_o    (ev_valid),
        .m_ev_ready_i    (ev_ready)
    );

    ////////////////////////////////////////////////////////////////////////////
    // model and checking
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input logic [64:0] got, input logic [64:0] exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    function automatic int lowest_unmasked(input link_mask_t mask);
        for (int i = 0; i < NUM_LINKS; i++) begin
            if (!mask[i]) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic reg_data_t model_read(input reg_addr_t addr);
        case (addr)
            4, 5, 6, 7, 12, 13, 14, 15: return mdl_link_cnt[addr[1:0]];
            8: return mdl_out_beats;
            9: return mdl_hdr_rx;
            default: return {20'h0, mdl_mask, 7'h0, mdl_reset};
        endcase
    endfunction

    task automatic expect_header();
        hdr_beat_t b;
        b.data = {HDR_MAGIC, 16'h0000, mdl_ev_num};
        b.last = 1'b0;
        hdr_q.push_back(b);
        b.data = {60'h0, mdl_mask};
        b.last = 1'b1;
        hdr_q.push_back(b);
        mdl_ev_num++;
    endtask

    task automatic clear_model();
        for (int i = 0; i < NUM_LINKS; i++) begin
            mdl_link_cnt[i] = '0;
        end
        mdl_out_beats = '0;
        mdl_hdr_rx    = '0;
        mdl_ev_num    = '0;
        hdr_q.delete();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // bus tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic reg_access(input logic we, input reg_addr_t addr, input logic [3:0] be,
                              input reg_data_t wdata, output reg_data_t data);
        @(posedge aclk);
        req.addr  <= addr;
        req.we    <= we;
        req.be    <= be;
        req.wdata <= wdata;
        req_valid <= 1'b1;
        @(negedge aclk);
        check_value(ack, 1'b0, "ack before request is sampled");
        @(negedge aclk);
        check_value(ack, 1'b1, "ack one cycle after request");
        data = rdata;
        @(posedge aclk);
        req_valid <= 1'b0;
        @(negedge aclk);
        check_value(ack, 1'b1, "ack held while request high");
        @(negedge aclk);
        check_value(ack, 1'b0, "ack released after request low");
    endtask

    task automatic send_packet(input int link, input int len, input logic [7:0] rdy_pat);
        int         sent;
        int         cyc;
        logic       rdy_exp;
        link_beat_t b;
        sent   = 0;
        cyc    = 0;
        b.data = $random(seed);
        while (sent < len) begin
            b.last  = (sent == len - 1);
            rdy_exp = mdl_open ? rdy_pat[cyc % 8] : 1'b1;
            @(posedge aclk);
            s_beat[link]  <= b;
            s_valid[link] <= 1'b1;
            m_ready[link] <= rdy_pat[cyc % 8];
            @(negedge aclk);
            check_value(s_ready[link], rdy_exp, "link ready");
            check_value(m_valid[link], mdl_open, "gated link valid");
            if (mdl_open) begin
                check_value(m_beat[link], b, "gated link beat");
            end
            if (rdy_exp) begin
                if (mdl_open) begin
                    mdl_link_cnt[link]++;
                    if (b.last && lowest_unmasked(mdl_mask) == link) begin
                        expect_header();
                    end
                end
                sent++;
                b.data = $random(seed);
            end
            cyc++;
        end
        @(posedge aclk);
        s_valid[link] <= 1'b0;
        m_ready[link] <= 1'b1;
    endtask

    task automatic drain_headers(input int count, input logic random_ready);
        logic [31:0] rnd;
        logic        rdy;
        check_value(hdr_q.size() / 2, count, "headers predicted by model");
        while (hdr_q.size() > 0) begin
            rnd = $random(seed);
            rdy = rnd[0] | !random_ready;
            @(posedge aclk);
            ev_ready <= rdy;
            @(negedge aclk);
            // a stalled beat is compared again each cycle
            if (ev_valid) begin
                check_value(ev_beat, hdr_q[0], "header beat");
                if (rdy) begin
                    mdl_out_beats++;
                    if (hdr_q[0].last) begin
                        mdl_hdr_rx++;
                    end
                    void'(hdr_q.pop_front());
                end
            end
        end
        @(posedge aclk);
        ev_ready <= 1'b1;
        repeat (8) begin
            @(negedge aclk);
            check_value(ev_valid, 1'b0, "no further header");
        end
        @(posedge aclk);
        ev_ready <= 1'b0;
    endtask

    task automatic run_row(input row_t r);
        reg_data_t data;
        case (r.op)
            OP_WR: begin
                reg_access(1'b1, r.arg, r.len, r.data, data);
                if (r.len[0]) begin
                    mdl_reset = r.data[0];
                end
                if (r.len[1]) begin
                    mdl_mask = r.data[11:8];
                end
                if (mdl_reset) begin
                    clear_model();
                end
            end
            OP_RD: begin
                reg_access(1'b0, r.arg, 4'h0, '0, data);
                check_value(data, model_read(r.arg), $sformatf("read index %0d", r.arg));
            end
            OP_PKT: send_packet(r.arg, r.len, r.data[7:0]);
            OP_DRAIN: drain_headers(r.exp, r.arg[0]);
            default: begin
                @(posedge aclk);
                event_open <= r.arg[0];
                // synchroniser delay
                repeat (3) @(posedge aclk);
                mdl_open = r.arg[0];
            end
        endcase
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // table
    ////////////////////////////////////////////////////////////////////////////

    task automatic add_row(input op_t op, input int arg, input int len,
                           input logic [31:0] data, input int exp);
        row_t r;
        r.op   = op;
        r.arg  = arg;
        r.len  = len;
        r.data = data;
        r.exp  = exp;
        rows.push_back(r);
    endtask

    function automatic int row_cycles(input row_t r);
        case (r.op)
            OP_PKT: return r.len * 8 + 4;
            OP_DRAIN: return r.exp * 16 + 12;
            default: return 8;
        endcase
    endfunction

    task automatic load_table();
        // global word, byte enables and aliases
        add_row(OP_WR, 0, 4'b0010, 32'hFFFF_F5FF, 0);
        add_row(OP_RD, 0, 0, 0, 0);
        add_row(OP_RD, 3, 0, 0, 0);
        add_row(OP_RD, 10, 0, 0, 0);
        add_row(OP_RD, 11, 0, 0, 0);
        add_row(OP_WR, 13, 4'b0001, 32'hFFFF_FFFF, 0);
        add_row(OP_RD, 1, 0, 0, 0);
        add_row(OP_WR, 2, 4'b0011, 32'h0, 0);
        add_row(OP_RD, 2, 0, 0, 0);
        // gating closed, then open with link back-pressure
        add_row(OP_PKT, 2, 3, 32'h5A, 0);
        add_row(OP_RD, 6, 0, 0, 0);
        add_row(OP_OPEN, 1, 0, 0, 0);
        add_row(OP_PKT, 2, 5, 32'h5B, 0);
        add_row(OP_PKT, 3, 2, 32'hD3, 0);
        add_row(OP_RD, 6, 0, 0, 0);
        add_row(OP_RD, 14, 0, 0, 0);
        add_row(OP_RD, 7, 0, 0, 0);
        add_row(OP_RD, 15, 0, 0, 0);
        // start detection and masking
        add_row(OP_PKT, 0, 4, 32'hFF, 0);
        add_row(OP_DRAIN, 0, 0, 0, 1);
        add_row(OP_WR, 0, 4'b0010, 32'h100, 0);
        add_row(OP_PKT, 0, 2, 32'hFF, 0);
        add_row(OP_DRAIN, 0, 0, 0, 0);
        add_row(OP_PKT, 1, 3, 32'hFF, 0);
        add_row(OP_DRAIN, 0, 0, 0, 1);
        // three starts queued behind a stalled output
        add_row(OP_WR, 0, 4'b0010, 32'h800, 0);
        add_row(OP_PKT, 0, 1, 32'hFF, 0);
        add_row(OP_PKT, 0, 1, 32'hFF, 0);
        add_row(OP_PKT, 0, 1, 32'hFF, 0);
        add_row(OP_DRAIN, 1, 0, 0, 3);
        add_row(OP_RD, 8, 0, 0, 0);
        add_row(OP_RD, 9, 0, 0, 0);
        // soft reset clears statistics and event number, keeps the mask
        add_row(OP_WR, 0, 4'b0001, 32'h1, 0);
        add_row(OP_WR, 0, 4'b0001, 32'h0, 0);
        add_row(OP_RD, 4, 0, 0, 0);
        add_row(OP_RD, 8, 0, 0, 0);
        add_row(OP_RD, 9, 0, 0, 0);
        add_row(OP_RD, 0, 0, 0, 0);
        add_row(OP_PKT, 0, 2, 32'hFF, 0);
        add_row(OP_DRAIN, 1, 0, 0, 1);
        add_row(OP_RD, 9, 0, 0, 0);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // run
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge aclk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: the run did not finish within %0d cycles", limit);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        int err_before;
        seed       = 32'h8a8;
        errors     = 0;
        checks     = 0;
        cycles     = 0;
        limit      = 0;
        rst_n      = 1'b0;
        req        = '0;
        req_valid  = 1'b0;
        event_open = 1'b0;
        s_valid    = '0;
        m_ready    = '1;
        ev_ready   = 1'b0;
        for (int i = 0; i < NUM_LINKS; i++) begin
            s_beat[i] = '0;
        end
        mdl_reset = 1'b0;
        mdl_mask  = '0;
        mdl_open  = 1'b0;
        clear_model();
        load_table();
        limit = 10 + 200;
        for (int i = 0; i < rows.size(); i++) begin
            limit += row_cycles(rows[i]);
        end
        repeat (10) @(posedge aclk);
        rst_n <= 1'b1;
        @(negedge aclk);
        check_value(ack, 1'b0, "ack after reset");
        check_value(ev_valid, 1'b0, "header valid after reset");
        for (int i = 0; i < rows.size(); i++) begin
            err_before = errors;
            run_row(rows[i]);
            $display("test %0d %s: %s", i, rows[i].op.name(),
                     (errors == err_before) ? "ok" : "error");
        end
        $display("%0d tests, %0d checks, %0d errors", rows.size(), checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== files.f ====
hw/event_pkg.sv
hw/event_regs.sv
hw/event_stat_counter.sv
hw/link_gate.sv
hw/event_start_detect.sv
hw/turf_header_gen.sv
hw/event_top.sv
tests/tb_clock.sv
tests/tb_event_top.sv
